// File: include/synth.svh
`ifndef SYNTH_SVH
`define SYNTH_SVH

// reinterpret a vector with another signedness, no width change
`define CAST(kind, val) kind'(val)

`endif

// File: verilog/exec_pkg.sv
`default_nettype none

package exec_pkg;

    // datapath geometry, fixed by the RV32I encoding
    localparam int XLEN  = 32;
    localparam int NREGS = 32;

    // major opcodes handled by the execute path
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    // funct3 field
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7 field
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // only add and sub have bits 1 and 2 clear, the alu relies on this
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_AND  = 4'b0100,
        ALU_OR   = 4'b0101,
        ALU_XOR  = 4'b0110,
        ALU_SLL  = 4'b0111,
        ALU_SRL  = 4'b1010,
        ALU_SRA  = 4'b1011
    } alu_op_e;

    // overflow sits at bit 0, negative at bit 3
    typedef struct packed {
        logic negative;
        logic zero;
        logic carry;
        logic overflow;
    } alu_flags_t;

    typedef struct packed {
        alu_op_e     op;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
        logic        use_imm;
        logic        illegal;
    } dec_t;

endpackage

`default_nettype wire

// File: verilog/alu.sv
`timescale 1ns/1ns
`default_nettype none

`include "synth.svh"

module alu import exec_pkg::*; (
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  alu_op_e         op,
    output logic [XLEN-1:0] res,
    output alu_flags_t      flags
);

    logic [XLEN-1:0]        b_op;
    logic [XLEN-1:0]        sum;
    logic                   cin;
    logic                   co;
    logic                   sub_mode;
    logic [4:0]             shamt;
    logic signed [XLEN-1:0] a_signed;
    logic                   ov_add;
    logic                   ov_sub;

    // everything except add runs the adder as a - b
    assign sub_mode = (op != ALU_ADD);
    assign b_op     = sub_mode ? ~b : b;
    assign cin      = sub_mode;

    assign {co, sum} = {1'b0, a} + {1'b0, b_op} + {{XLEN{1'b0}}, cin};

    // RV32I shifts only look at the low five bits
    assign shamt    = b[4:0];
    assign a_signed = `CAST(signed, a);

    // sign cases for a + b
    assign ov_add = (~a[XLEN-1] & ~b[XLEN-1] &  sum[XLEN-1]) |
                    ( a[XLEN-1] &  b[XLEN-1] & ~sum[XLEN-1]);

    // sign cases for a - b
    assign ov_sub = ( a[XLEN-1] & ~b[XLEN-1] & ~sum[XLEN-1]) |
                    (~a[XLEN-1] &  b[XLEN-1] &  sum[XLEN-1]);

    always_comb begin
        case (op)
            ALU_ADD: begin
                res = sum;
            end
            ALU_SUB: begin
                res = sum;
            end
            ALU_SLT: begin
                // true difference sign, corrected for overflow
                res = {{(XLEN-1){1'b0}}, sum[XLEN-1] ^ ov_sub};
            end
            ALU_SLTU: begin
                // no carry out of a + ~b + 1 means a < b
                res = {{(XLEN-1){1'b0}}, ~co};
            end
            ALU_AND: begin
                res = a & b;
            end
            ALU_OR: begin
                res = a | b;
            end
            ALU_XOR: begin
                res = a ^ b;
            end
            ALU_SLL: begin
                res = a << shamt;
            end
            ALU_SRL: begin
                res = a >> shamt;
            end
            ALU_SRA: begin
                res = a_signed >>> shamt;
            end
            default: begin
                res = '0;
            end
        endcase
    end

    // overflow only for add and sub
    assign flags.overflow = (op == ALU_ADD) ? ov_add :
                            (op == ALU_SUB) ? ov_sub : 1'b0;

    // carry qualified by the opcode encoding, add and sub only
    assign flags.carry    = co & ~op[1] & ~op[2];
    assign flags.zero     = ~(|res);
    assign flags.negative = res[XLEN-1];

    // decoder always resolves to a defined operation
    op_known: assert final (!$isunknown(op));

endmodule

`default_nettype wire

// File: verilog/instr_decode.sv
`timescale 1ns/1ns
`default_nettype none

module instr_decode import exec_pkg::*; (
    input  logic [31:0] instr,
    output dec_t        dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       f7_base;
    logic       f7_alt;

    assign opcode  = instr[6:0];
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign f7_base = (funct7 == F7_BASE);
    assign f7_alt  = (funct7 == F7_ALT);

    always_comb begin
        dec.rd      = instr[11:7];
        dec.rs1     = instr[19:15];
        dec.rs2     = instr[24:20];
        dec.imm     = {{20{instr[31]}}, instr[31:20]};
        dec.use_imm = (opcode == OPC_OP_IMM);
        dec.op      = ALU_ADD;
        dec.illegal = 1'b0;

        case (opcode)
            OPC_OP: begin
                case (funct3)
                    F3_ADD_SUB: dec.op = f7_alt ? ALU_SUB : ALU_ADD;
                    F3_SLL:     dec.op = ALU_SLL;
                    F3_SLT:     dec.op = ALU_SLT;
                    F3_SLTU:    dec.op = ALU_SLTU;
                    F3_XOR:     dec.op = ALU_XOR;
                    F3_SR:      dec.op = f7_alt ? ALU_SRA : ALU_SRL;
                    F3_OR:      dec.op = ALU_OR;
                    default:    dec.op = ALU_AND;
                endcase
                // alt form exists only for sub and sra
                if (f7_alt) begin
                    dec.illegal = (funct3 != F3_ADD_SUB) && (funct3 != F3_SR);
                end else if (!f7_base) begin
                    dec.illegal = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                case (funct3)
                    F3_ADD_SUB: dec.op = ALU_ADD;
                    F3_SLL: begin
                        dec.op      = ALU_SLL;
                        dec.illegal = !f7_base;
                    end
                    F3_SLT:     dec.op = ALU_SLT;
                    F3_SLTU:    dec.op = ALU_SLTU;
                    F3_XOR:     dec.op = ALU_XOR;
                    F3_SR: begin
                        dec.op      = f7_alt ? ALU_SRA : ALU_SRL;
                        dec.illegal = !(f7_base || f7_alt);
                    end
                    F3_OR:      dec.op = ALU_OR;
                    default:    dec.op = ALU_AND;
                endcase
                // upper bits are plain immediate outside the shifts
            end
            default: begin
                dec.illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file import exec_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    output logic [XLEN-1:0] rs1_data,
    output logic [XLEN-1:0] rs2_data,
    input  logic            we,
    input  logic [4:0]      rd,
    input  logic [XLEN-1:0] rd_data
);

    logic [XLEN-1:0] mem [NREGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NREGS; i++) begin
                mem[i] <= '0;
            end
        end else if (we && (rd != '0)) begin
            mem[rd] <= rd_data;
        end
    end

    // x0 is hardwired, reads see the updated array
    assign rs1_data = (rs1 == '0) ? '0 : mem[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : mem[rs2];

    // a write aimed at x0 leaves the entry at zero
    x0_untouched: assert property (
        @(posedge clk) disable iff (rst)
        (we && (rd == '0)) |=> (mem[0] == '0)
    );

endmodule

`default_nettype wire

// File: verilog/exec_unit.sv
`timescale 1ns/1ns
`default_nettype none

module exec_unit import exec_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            instr_valid,
    input  logic [31:0]     instr,
    output logic            result_valid,
    output logic [XLEN-1:0] result,
    output alu_flags_t      flags,
    output logic [4:0]      result_rd,
    output logic            illegal
);

    dec_t            dec;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_res;
    alu_flags_t      alu_flags;
    logic            wr_en;

    instr_decode u_decode (
        .instr (instr),
        .dec   (dec)
    );

    // write happens on the same edge that captures the result
    assign wr_en = instr_valid && !dec.illegal;

    reg_file u_regs (
        .clk      (clk),
        .rst      (rst),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (wr_en),
        .rd       (dec.rd),
        .rd_data  (alu_res)
    );

    // OP-IMM takes the immediate as operand b
    assign op_b = dec.use_imm ? dec.imm : rs2_data;

    alu u_alu (
        .a     (rs1_data),
        .b     (op_b),
        .op    (dec.op),
        .res   (alu_res),
        .flags (alu_flags)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
            illegal      <= 1'b0;
            result       <= '0;
            flags        <= '0;
            result_rd    <= '0;
        end else begin
            result_valid <= wr_en;
            illegal      <= instr_valid && dec.illegal;
            if (wr_en) begin
                result    <= alu_res;
                flags     <= alu_flags;
                result_rd <= dec.rd;
            end
        end
    end

    // each strobe reports either a result or an illegal word
    one_outcome: assert property (
        @(posedge clk) disable iff (rst)
        !(result_valid && illegal)
    );

endmodule

`default_nettype wire

// File: tests/exec_unit_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "synth.svh"

module exec_unit_tb
    import exec_pkg::*;
();

    localparam int PERIOD     = 8;
    localparam int RST_CYCLES = 16;
    localparam int N_RAND     = 200;
    localparam int N_EDGE     = 60;
    localparam int N_DEP      = 20;
    localparam int N_ILL      = 40;
    localparam int N_SHIFT    = 20;
    localparam int N_INSTR    = 32 + 30 + N_RAND + 15 + N_EDGE + 2 * N_DEP + 4
                                + 2 * N_ILL + 13 * N_SHIFT;

    typedef struct packed {
        logic        want_valid;
        logic        want_illegal;
        logic [31:0] res;
        alu_flags_t  flags;
        logic [4:0]  rd;
    } exp_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        instr_valid;
    logic [31:0] instr;
    logic        result_valid;
    logic [31:0] result;
    alu_flags_t  flags;
    logic [4:0]  result_rd;
    logic        illegal;

    logic [31:0] model_regs [NREGS];
    exp_t        cur_exp;
    exp_t        due_exp;
    int          n_pass;
    int          n_fail;
    int          test_fail;

    exec_unit uut (.*);

    always #(PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    // expected outcome of one word, updates the model registers
    function automatic exp_t model_step(input logic [31:0] w);
        exp_t        e;
        logic [31:0] a;
        logic [31:0] b;
        logic [32:0] wide;
        logic        is_imm;
        logic        alt;
        logic        sub;
        e      = '0;
        is_imm = (w[6:0] == OPC_OP_IMM);
        alt    = (w[31:25] == F7_ALT);
        sub    = alt && !is_imm;
        a      = model_regs[w[19:15]];
        b      = is_imm ? {{20{w[31]}}, w[31:20]} : model_regs[w[24:20]];
        e.want_illegal = (!is_imm && w[6:0] != OPC_OP)
            || (!is_imm && !alt && w[31:25] != F7_BASE)
            || (sub && w[14:12] != F3_ADD_SUB && w[14:12] != F3_SR)
            || (is_imm && w[14:12] == F3_SLL && w[31:25] != F7_BASE)
            || (is_imm && w[14:12] == F3_SR && !alt && w[31:25] != F7_BASE);
        if (e.want_illegal)
            return e;
        case (w[14:12])
            F3_ADD_SUB: begin
                wide             = sub ? {1'b0, a} - {1'b0, b} : {1'b0, a} + {1'b0, b};
                e.res            = wide[31:0];
                // carry of a + ~b + 1 is the inverted borrow
                e.flags.carry    = wide[32] ^ sub;
                e.flags.overflow = ((a[31] ^ b[31]) == sub) && (e.res[31] != a[31]);
            end
            F3_SLT:  e.res = {31'd0, `CAST(signed, a) < `CAST(signed, b)};
            F3_SLTU: e.res = {31'd0, a < b};
            F3_XOR:  e.res = a ^ b;
            F3_OR:   e.res = a | b;
            F3_AND:  e.res = a & b;
            F3_SLL:  e.res = a << b[4:0];
            default: begin
                if (alt)
                    e.res = `CAST(signed, a) >>> b[4:0];
                else
                    e.res = a >> b[4:0];
            end
        endcase
        e.want_valid     = 1'b1;
        e.rd             = w[11:7];
        e.flags.zero     = (e.res == '0);
        e.flags.negative = e.res[31];
        if (w[11:7] != 5'd0)
            model_regs[w[11:7]] = e.res;
        return e;
    endfunction

    task automatic issue(input logic [31:0] w);
        exp_t e;
        e = model_step(w);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= w;
        cur_exp     <= e;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            instr_valid <= 1'b0;
            instr       <= $urandom;
            cur_exp     <= '0;
        end
    endtask

    // any 32-bit value from three immediates and two shifts
    task automatic load_value(input logic [4:0] rd, input logic [31:0] v);
        issue(enc_i({1'b0, v[31:21]}, 5'd0, F3_ADD_SUB, rd));
        issue(enc_i(12'd11, rd, F3_SLL, rd));
        issue(enc_i({1'b0, v[20:10]}, rd, F3_OR, rd));
        issue(enc_i(12'd10, rd, F3_SLL, rd));
        issue(enc_i({2'b0, v[9:0]}, rd, F3_OR, rd));
    endtask

    function automatic logic [31:0] rand_legal();
        logic [31:0] w;
        logic        alt;
        w   = $urandom;
        alt = $urandom_range(1, 0);
        if (w[14:12] != F3_ADD_SUB && w[14:12] != F3_SR)
            alt = 1'b0;
        if ($urandom_range(1, 0))
            return {alt ? F7_ALT : F7_BASE, w[24:7], OPC_OP};
        if (w[14:12] == F3_SLL || w[14:12] == F3_SR)
            w[31:25] = alt ? F7_ALT : F7_BASE;
        return {w[31:7], OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] rand_illegal();
        logic [31:0] w;
        logic [6:0]  f7;
        w  = $urandom;
        f7 = $urandom;
        while (f7 == F7_BASE || f7 == F7_ALT)
            f7 = $urandom;
        case ($urandom_range(2, 0))
            0: begin
                while (w[6:0] == OPC_OP || w[6:0] == OPC_OP_IMM)
                    w[6:0] = $urandom;
            end
            1: w = {f7, w[24:7], OPC_OP};
            // slli accepts only the base funct7
            default: w = {w[0] ? F7_ALT : f7, w[24:15], F3_SLL, w[11:7], OPC_OP_IMM};
        endcase
        return w;
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) n_pass++;
        else begin
            $display("ERR %s exp %h got %h", name, exp, got);
            n_fail++;
        end
    endtask

    task automatic end_test(input string name);
        idle(3);
        $display("test %s finished with %0d errors", name, n_fail - test_fail);
        test_fail = n_fail;
    endtask

    always @(posedge clk)
        due_exp <= cur_exp;

    // outputs checked mid-cycle, one cycle after the strobe
    always @(negedge clk) begin
        if (!rst) begin
            compare("result_valid", due_exp.want_valid, result_valid);
            compare("illegal", due_exp.want_illegal, illegal);
            if (due_exp.want_valid) begin
                compare("result", due_exp.res, result);
                compare("flags", due_exp.flags, flags);
                compare("result_rd", due_exp.rd, result_rd);
            end
        end
    end

    initial begin
        #((N_INSTR * 16 + RST_CYCLES) * PERIOD);
        $display("watchdog expired before the tests completed");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        logic [31:0] w;
        logic [4:0]  d;
        void'($urandom(94));
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        cur_exp     = '0;
        n_pass      = 0;
        n_fail      = 0;
        test_fail   = 0;
        for (int i = 0; i < NREGS; i++)
            model_regs[i] = '0;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;

        idle(4);
        for (int n = 0; n < NREGS; n++)
            issue(enc_r(F7_BASE, 5'd0, 5'(n), F3_ADD_SUB, 5'(n)));
        end_test("reset_reads");

        for (int n = 1; n <= 6; n++)
            load_value(5'(n), $urandom);
        for (int i = 0; i < N_RAND; i++) begin
            issue(rand_legal());
            if ($urandom_range(3, 0) == 0)
                idle($urandom_range(2, 1));
        end
        end_test("random_ops");

        load_value(5'd1, 32'h7fffffff);
        load_value(5'd2, 32'h80000000);
        load_value(5'd3, 32'hffffffff);
        for (int i = 0; i < N_EDGE; i++) begin
            d = 5'(16 + $urandom_range(15, 0));
            w = enc_r($urandom_range(1, 0) ? F7_ALT : F7_BASE, 5'($urandom_range(3, 0)),
                      5'($urandom_range(3, 0)), F3_ADD_SUB, d);
            issue(w);
        end
        end_test("edge_flags");

        for (int i = 0; i < N_DEP; i++) begin
            d = 5'($urandom_range(31, 1));
            issue(enc_i(12'($urandom), 5'($urandom), F3_ADD_SUB, d));
            issue(enc_r(F7_BASE, d, 5'($urandom), F3_XOR, 5'($urandom)));
        end
        // x0 writes are dropped
        issue(enc_i(12'h123, 5'd1, F3_ADD_SUB, 5'd0));
        issue(enc_r(F7_BASE, 5'd0, 5'd0, F3_OR, 5'd5));
        issue(enc_r(F7_ALT, 5'd1, 5'd0, F3_ADD_SUB, 5'd0));
        issue(enc_r(F7_BASE, 5'd2, 5'd0, F3_ADD_SUB, 5'd6));
        end_test("back_to_back");

        for (int i = 0; i < N_ILL; i++) begin
            w = rand_illegal();
            issue(w);
            // read back the register named as rd
            issue(enc_r(F7_BASE, 5'd0, w[11:7], F3_ADD_SUB, 5'd0));
        end
        end_test("illegal_words");

        for (int i = 0; i < N_SHIFT; i++) begin
            load_value(5'd8, $urandom | 32'h20);
            load_value(5'd9, $urandom);
            issue(enc_r(F7_BASE, 5'd8, 5'd9, F3_SLL, 5'd10));
            issue(enc_r(F7_BASE, 5'd8, 5'd9, F3_SR, 5'd11));
            issue(enc_r(F7_ALT, 5'd8, 5'd9, F3_SR, 5'd12));
        end
        end_test("wide_shifts");

        $display("checks passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+include
verilog/exec_pkg.sv
verilog/alu.sv
verilog/instr_decode.sv
verilog/reg_file.sv
verilog/exec_unit.sv
tests/exec_unit_tb.sv

// File: Bender.yml
package:
  name: exec_unit

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/exec_pkg.sv
      - verilog/alu.sv
      - verilog/instr_decode.sv
      - verilog/reg_file.sv
      - verilog/exec_unit.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/exec_unit_tb.sv
